/* design/alu.sv */
// Combinational ALU with arithmetic, logic, shift, pass and multiply step.
`default_nettype none

module alu
	import cpuPkg::*;
(
	input  aluOpT               op,
	input  logic [Bits-1:0]     a,
	input  logic [Bits-1:0]     b,
	input  logic [StepBits-1:0] stepIndex,  // Current multiply bit.
	input  logic [Bits-1:0]     acc,        // Running product, rd.
	output logic [Bits-1:0]     result
);

	logic [Bits-1:0] partial;  // a weighted by the current step.
	logic            bitSet;   // Multiplier bit for this step.

	assign partial = a << stepIndex;
	assign bitSet  = b[stepIndex];

	always_comb
	begin
		case (op)
			aluAdd:
				result = a + b;
			aluSub:
				result = a - b;
			aluAnd:
				result = a & b;
			aluOr:
				result = a | b;
			aluXor:
				result = a ^ b;
			aluShl:
				result = a << b;  // Amounts of 16 or more give zero.
			aluShr:
				result = a >> b;  // Logical.
			aluPassA:
				result = a;       // Jump target.
			aluMulStep:
			begin
				// Shift-and-add, one multiplier bit per cycle.
				if (bitSet)
					result = acc + partial;
				else
					result = acc;
			end
			default:
				result = a;
		endcase
	end

endmodule

`default_nettype wire

/* design/cpuCore.sv */
// Core top level joining sequencer, step counter, register file and ALU.
`default_nettype none

module cpuCore
	import cpuPkg::*;
(
	input  logic            CLK,
	input  logic            reset,
	output logic [Bits-1:0] memAddr,
	output logic [Bits-1:0] memWrData,
	output logic            memRead,
	output logic            memWrite,
	output logic            halted,
	input  logic [Bits-1:0] memRdData,
	input  logic            memReady
);

	aluOpT               aluOp;
	logic                startMul;
	logic                lastStep;
	logic [StepBits-1:0] stepIndex;
	logic [Bits-1:0]     aluA;
	logic [Bits-1:0]     aluB;
	logic [Bits-1:0]     aluResult;

	regFileCtrlIf rfCtrl();  // Sequencer to register file.

	sequencer iSeq
	(
		.CLK       (CLK),
		.reset     (reset),
		.rf        (rfCtrl.ctrl),
		.aluOp     (aluOp),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.halted    (halted),
		.startMul  (startMul),
		.lastStep  (lastStep),
		.memReady  (memReady),
		.memRdData (memRdData)
	);

	iterCounter iCounter
	(
		.CLK       (CLK),
		.reset     (reset),
		.start     (startMul),
		.stepIndex (stepIndex),
		.lastStep  (lastStep)
	);

	// Data and address ports drive the memory bus directly.
	registerFile iRegs
	(
		.CLK     (CLK),
		.reset   (reset),
		.ctrl    (rfCtrl.regs),
		.aluIn   (aluResult),
		.memIn   (memRdData),
		.aluA    (aluA),
		.aluB    (aluB),
		.memData (memWrData),
		.memAddr (memAddr)
	);

	// Accumulator shares the memory data port.
	alu iAlu
	(
		.op        (aluOp),
		.a         (aluA),
		.b         (aluB),
		.stepIndex (stepIndex),
		.acc       (memWrData),
		.result    (aluResult)
	);

endmodule

`default_nettype wire

/* design/cpuPkg.sv */
// Width constants, opcode enum, ALU operation enum and sequencer state enum.
`default_nettype none

package cpuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int Bits     = 16;                // Data and instruction width.
	localparam int RegBits  = 3;                 // Register index width.
	localparam int NumRegs  = 8;                 // Registers in the file.
	localparam int PcReg    = 7;                 // r7 is the program counter.
	localparam int MulSteps = 16;                // One multiply step per operand bit.
	localparam int StepBits = $clog2(MulSteps);  // Width of the step index.

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// Opcode field, instruction bits 15 to 12.
	typedef enum logic [3:0]
	{
		opAdd  = 4'h0,
		opSub  = 4'h1,
		opAnd  = 4'h2,
		opOr   = 4'h3,
		opXor  = 4'h4,
		opShl  = 4'h5,
		opShr  = 4'h6,
		opLdi  = 4'h7,  // rd = zero-extended imm9.
		opLd   = 4'h8,  // rd = mem[ra].
		opSt   = 4'h9,  // mem[ra] = rd.
		opJmp  = 4'ha,  // r7 = ra.
		opMul  = 4'hb,  // rd = ra * rb, low 16 bits.
		opHalt = 4'hc
	} opcodeT;

	// ALU function select.
	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShl,
		aluShr,
		aluPassA,
		aluMulStep
	} aluOpT;

	// Sequencer states.
	typedef enum logic [2:0]
	{
		sFetch,
		sDecode,
		sExec,
		sMem,
		sMulClear,
		sMul,
		sHalt
	} seqStateT;

endpackage

`default_nettype wire

/* design/iterCounter.sv */
// Multiply step counter with ascending step index and last-step flag.
`default_nettype none

module iterCounter
	import cpuPkg::*;
(
	input  logic                CLK,
	input  logic                reset,
	input  logic                start,      // Load the step count.
	output logic [StepBits-1:0] stepIndex,  // 0 up to MulSteps-1.
	output logic                lastStep
);

	logic [StepBits:0] remaining;  // Steps left, zero when idle.

	always_ff @(posedge CLK)
	begin
		if (reset)
			remaining <= '0;
		else if (start)
			remaining <= MulSteps[StepBits:0];
		else if (remaining != '0)
			remaining <= remaining - 1'b1;
	end

	// Full count maps to 0, one left maps to the top step.
	assign stepIndex = MulSteps[StepBits-1:0] - remaining[StepBits-1:0];
	assign lastStep  = (remaining == 1);

endmodule

`default_nettype wire

/* design/regFileCtrlIf.sv */
// Register-file control interface with sequencer and register-file modports.
`default_nettype none

interface regFileCtrlIf
	import cpuPkg::*;
();

	// One-hot load vectors, one per write source.
	logic [NumRegs-1:0] loadAlu;   // Load from ALU result.
	logic [NumRegs-1:0] loadMem;   // Load from memory read data.
	logic [NumRegs-1:0] loadImm;   // Load from instruction immediate.

	logic [NumRegs-1:0] inc;       // Per-register increment, loads take priority.

	// Read port selectors.
	logic [RegBits-1:0] aluASel;
	logic [RegBits-1:0] aluBSel;
	logic [RegBits-1:0] memDataSel;
	logic [RegBits-1:0] memAddrSel;

	logic [Bits-1:0]    imm;          // Immediate value.
	logic               aluBFromImm;  // Immediate replaces the B bus.

	// Sequencer side.
	modport ctrl
	(
		output loadAlu, loadMem, loadImm, inc,
		output aluASel, aluBSel, memDataSel, memAddrSel,
		output imm, aluBFromImm
	);

	// Register file side.
	modport regs
	(
		input loadAlu, loadMem, loadImm, inc,
		input aluASel, aluBSel, memDataSel, memAddrSel,
		input imm, aluBFromImm
	);

endinterface

`default_nettype wire

/* design/registerFile.sv */
// Eight-entry register file with three load sources, increment and four read ports.
`default_nettype none

module registerFile
	import cpuPkg::*;
(
	input  logic            CLK,
	input  logic            reset,
	regFileCtrlIf.regs      ctrl,
	input  logic [Bits-1:0] aluIn,    // ALU result.
	input  logic [Bits-1:0] memIn,    // Memory read data.
	output logic [Bits-1:0] aluA,     // ALU A bus.
	output logic [Bits-1:0] aluB,     // ALU B bus.
	output logic [Bits-1:0] memData,  // Memory write data bus.
	output logic [Bits-1:0] memAddr   // Memory address bus.
);

	logic [Bits-1:0] regs [NumRegs];

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	// Loads beat increment on the same register.
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumRegs; i++)
				regs[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NumRegs; i++)
			begin
				if (ctrl.loadAlu[i])
					regs[i] <= aluIn;
				else if (ctrl.loadMem[i])
					regs[i] <= memIn;
				else if (ctrl.loadImm[i])
					regs[i] <= ctrl.imm;
				else if (ctrl.inc[i])
					regs[i] <= regs[i] + Bits'(1);  // PC advance.
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	// Decoded mux. Selector goes one-hot, then AND-OR across the file.
	function automatic logic [Bits-1:0] readPort(input logic [RegBits-1:0] sel);
		logic [NumRegs-1:0] hit;
		logic [Bits-1:0]    word;
		hit  = NumRegs'(1) << sel;
		word = '0;
		for (int i = 0; i < NumRegs; i++)
			word |= regs[i] & {Bits{hit[i]}};
		return word;
	endfunction

	always_comb
	begin
		aluA    = readPort(ctrl.aluASel);
		memData = readPort(ctrl.memDataSel);  // Also the multiply accumulator.
		memAddr = readPort(ctrl.memAddrSel);
		// B bus, or the immediate in its place.
		if (ctrl.aluBFromImm)
			aluB = ctrl.imm;
		else
			aluB = readPort(ctrl.aluBSel);
	end

endmodule

`default_nettype wire

/* design/sequencer.sv */
// Instruction register and control FSM for fetch, decode, execute, memory and multiply.
`default_nettype none

module sequencer
	import cpuPkg::*;
(
	input  logic            CLK,
	input  logic            reset,
	regFileCtrlIf.ctrl      rf,
	output aluOpT           aluOp,
	output logic            memRead,    // Held until memReady.
	output logic            memWrite,   // Held until memReady.
	output logic            halted,
	output logic            startMul,   // Kicks off the step counter.
	input  logic            lastStep,
	input  logic            memReady,
	input  logic [Bits-1:0] memRdData   // Instruction word on fetch.
);

	seqStateT        state;
	seqStateT        nextState;
	logic [Bits-1:0] ir;         // Instruction register.
	logic            nextRead;
	logic            nextWrite;
	logic            accessDone; // Strobe met by ready.

	// Instruction fields.
	opcodeT             opcode;
	logic [RegBits-1:0] rd;
	logic [RegBits-1:0] ra;
	logic [RegBits-1:0] rb;
	logic [Bits-1:0]    immZx;

	assign opcode = opcodeT'(ir[15:12]);
	assign rd     = ir[11:9];
	assign ra     = ir[8:6];
	assign rb     = ir[5:3];
	assign immZx  = Bits'(ir[8:0]);  // Zero-extended.

	assign accessDone = (memRead || memWrite) && memReady;
	assign halted     = (state == sHalt);

	function automatic logic [NumRegs-1:0] oneHot(input logic [RegBits-1:0] idx);
		return NumRegs'(1) << idx;
	endfunction

	// Register-register opcodes onto ALU functions.
	function automatic aluOpT toAluOp(input opcodeT op);
		case (op)
			opAdd:   return aluAdd;
			opSub:   return aluSub;
			opAnd:   return aluAnd;
			opOr:    return aluOr;
			opXor:   return aluXor;
			opShl:   return aluShl;
			opShr:   return aluShr;
			default: return aluPassA;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// State, strobes and instruction register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state    <= sFetch;
			memRead  <= 1'b0;
			memWrite <= 1'b0;
			ir       <= '0;
		end
		else
		begin
			state    <= nextState;
			memRead  <= nextRead;
			memWrite <= nextWrite;
			if (state == sFetch && accessDone)
				ir <= memRdData;  // Latched in the ready edge.
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Quiet defaults. Selectors follow the instruction fields.
		nextState      = state;
		nextRead       = 1'b0;
		nextWrite      = 1'b0;
		startMul       = 1'b0;
		aluOp          = aluPassA;
		rf.loadAlu     = '0;
		rf.loadMem     = '0;
		rf.loadImm     = '0;
		rf.inc         = '0;
		rf.aluASel     = ra;
		rf.aluBSel     = rb;
		rf.memDataSel  = rd;
		rf.memAddrSel  = RegBits'(PcReg);
		rf.imm         = immZx;
		rf.aluBFromImm = 1'b0;  // No immediate-operand ALU forms.

		case (state)
			sFetch:
			begin
				// Strobe rises the cycle after entry, drops after ready.
				if (accessDone)
				begin
					rf.inc    = oneHot(RegBits'(PcReg));
					nextState = sDecode;
				end
				else
					nextRead = 1'b1;
			end
			sDecode:
			begin
				case (opcode)
					opAdd, opSub, opAnd, opOr, opXor, opShl, opShr, opLdi, opJmp:
						nextState = sExec;
					opLd, opSt:
						nextState = sMem;
					opMul:
						nextState = sMulClear;
					opHalt:
						nextState = sHalt;
					default:
						nextState = sFetch;  // Unused codes act as no-ops.
				endcase
			end
			sExec:
			begin
				case (opcode)
					opLdi:
						rf.loadImm = oneHot(rd);
					opJmp:
						rf.loadAlu = oneHot(RegBits'(PcReg));  // Through aluPassA.
					default:
					begin
						aluOp      = toAluOp(opcode);
						rf.loadAlu = oneHot(rd);
					end
				endcase
				nextState = sFetch;
			end
			sMem:
			begin
				rf.memAddrSel = ra;  // Data port already on rd.
				if (accessDone)
				begin
					if (opcode == opLd)
						rf.loadMem = oneHot(rd);
					nextState = sFetch;
				end
				else
				begin
					nextRead  = (opcode == opLd);
					nextWrite = (opcode == opSt);
				end
			end
			sMulClear:
			begin
				rf.imm     = '0;  // Clear the accumulator.
				rf.loadImm = oneHot(rd);
				startMul   = 1'b1;
				nextState  = sMul;
			end
			sMul:
			begin
				aluOp      = aluMulStep;  // Accumulator read on memDataSel.
				rf.loadAlu = oneHot(rd);
				if (lastStep)
					nextState = sFetch;
			end
			sHalt:
				nextState = sHalt;  // Only reset leaves.
			default:
				nextState = sFetch;
		endcase
	end

endmodule

`default_nettype wire

/* regCore.f */
design/cpuPkg.sv
design/regFileCtrlIf.sv
design/registerFile.sv
design/alu.sv
design/iterCounter.sv
design/sequencer.sv
design/cpuCore.sv
tb/cpuCore_chk.sv
tb/cpuCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the regCore testbench with Verilator.
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module cpuCore_tb -f regCore.f
./obj_dir/VcpuCore_tb 2>&1 | tee "$LOG"

if grep -q "Done: errors found" "$LOG" || ! grep -q "Done: no errors" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"

/* tb/cpuCore_chk.sv */
// Memory port and halt protocol assertions, bound into cpuCore.
`default_nettype none

module cpuCore_chk
	import cpuPkg::*;
(
	input logic            CLK,
	input logic            reset,
	input logic [Bits-1:0] memAddr,
	input logic [Bits-1:0] memWrData,
	input logic            memRead,
	input logic            memWrite,
	input logic            memReady,
	input logic            halted
);

	////////////////////////////////////////////////////////////////////////////
	// Memory port
	////////////////////////////////////////////////////////////////////////////

	strobesExclusive: assert property (@(posedge CLK) disable iff (reset)
		!(memRead && memWrite))
		else $error("memRead and memWrite are high in the same cycle");

	// Waiting read keeps strobe and address.
	readHeld: assert property (@(posedge CLK) disable iff (reset)
		(memRead && !memReady) |=> (memRead && $stable(memAddr)))
		else $error("read strobe or address changed before memReady");

	writeHeld: assert property (@(posedge CLK) disable iff (reset)
		(memWrite && !memReady) |=> (memWrite && $stable(memAddr) && $stable(memWrData)))
		else $error("write strobe, address or data changed before memReady");

	// Access ends in the ready cycle.
	strobeDrops: assert property (@(posedge CLK) disable iff (reset)
		((memRead || memWrite) && memReady) |=> !(memRead || memWrite))
		else $error("strobe still high in the cycle after memReady");

	////////////////////////////////////////////////////////////////////////////
	// Halt
	////////////////////////////////////////////////////////////////////////////

	haltSticky: assert property (@(posedge CLK) disable iff (reset)
		halted |=> halted)
		else $error("halted dropped without a reset");

	haltQuiet: assert property (@(posedge CLK) disable iff (reset)
		halted |-> !(memRead || memWrite))
		else $error("memory strobe raised while halted");

endmodule

bind cpuCore cpuCore_chk iChk
(
	.CLK       (CLK),
	.reset     (reset),
	.memAddr   (memAddr),
	.memWrData (memWrData),
	.memRead   (memRead),
	.memWrite  (memWrite),
	.memReady  (memReady),
	.halted    (halted)
);

`default_nettype wire

/* tb/cpuCore_tb.sv */
// Testbench for cpuCore with clock, reset, random-latency memory, test program and result checks.
`default_nettype none

module cpuCore_tb
	import cpuPkg::*;
();

	localparam int         HalfPeriod  = 50;
	localparam int         MemWords    = 256;
	localparam int         MaxInstr    = 40;          // Program length with margin.
	localparam int         WorstCycles = 25;          // Slowest instruction with its fetch.
	localparam int         WatchdogTime = MaxInstr * WorstCycles * 2 * HalfPeriod;
	localparam int         NumAluTests = 8;
	localparam logic [8:0] ImmA        = 9'h1a5;      // Top bit set for zero-extension.
	localparam logic [8:0] ImmB        = 9'h0c3;
	localparam logic [8:0] ImmSh       = 9'h005;      // Shift amount.
	localparam logic [7:0] ResultBase  = 8'h80;       // One word per ALU test.
	localparam logic [7:0] LoadSrc     = 8'h90;
	localparam logic [7:0] CopyDst     = 8'h88;
	localparam logic [7:0] PoisonDst   = ImmB[7:0];   // Target of the skipped store.

	logic            CLK       = 1'b0;
	logic            reset;
	logic [Bits-1:0] memAddr;
	logic [Bits-1:0] memWrData;
	logic            memRead;
	logic            memWrite;
	logic            halted;
	logic [Bits-1:0] memRdData = '0;
	logic            memReady  = 1'b0;

	logic [Bits-1:0] mem [MemWords];
	logic [31:0]     lcgState  = 32'h2a8b;
	logic [1:0]      waitLeft  = '0;        // Cycles before ready.
	int              progLen   = 0;
	opcodeT          testOps   [NumAluTests] = '{opAdd, opSub, opAnd, opOr, opXor, opShl, opShr, opMul};
	string           testNames [NumAluTests] = '{"add", "sub", "and", "or", "xor", "shl", "shr", "mul"};

	cpuCore i_dut
	(
		.CLK       (CLK),
		.reset     (reset),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.halted    (halted),
		.memRdData (memRdData),
		.memReady  (memReady)
	);

	always #HalfPeriod CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// Helpers and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Background word, every address bit matters.
	function automatic logic [Bits-1:0] fillWord(input logic [7:0] addr);
		return {addr ^ 8'h5a, ~addr};
	endfunction

	function automatic logic [Bits-1:0] encodeRegs(input opcodeT op, input logic [2:0] rd,
		input logic [2:0] ra, input logic [2:0] rb);
		return {op, rd, ra, rb, 3'b000};
	endfunction

	function automatic logic [Bits-1:0] encodeImm(input opcodeT op, input logic [2:0] rd,
		input logic [8:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [Bits-1:0] zeroExtend(input logic [8:0] imm);
		return {7'd0, imm};
	endfunction

	function automatic logic isShift(input opcodeT op);
		return (op == opShl) || (op == opShr);
	endfunction

	// Expected rd after one instruction, truncated to a word.
	function automatic logic [Bits-1:0] expectedResult(input opcodeT op,
		input logic [Bits-1:0] a, input logic [Bits-1:0] b);
		logic [2*Bits-1:0] product;
		product = a * b;
		case (op)
			opAdd:   return a + b;
			opSub:   return a - b;
			opAnd:   return a & b;
			opOr:    return a | b;
			opXor:   return a ^ b;
			opShl:   return a << b;
			opShr:   return a >> b;
			opMul:   return product[Bits-1:0];  // Low half only.
			default: return '0;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [Bits-1:0] expected,
		input logic [Bits-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic emit(input logic [Bits-1:0] word);
		mem[8'(progLen)] = word;
		progLen++;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < MemWords; i++)
			mem[i[7:0]] = fillWord(8'(i));
		emit(encodeImm(opLdi, 3'd1, ImmA));
		emit(encodeImm(opLdi, 3'd2, ImmB));
		emit(encodeImm(opLdi, 3'd3, ImmSh));
		// Op into r4, address into r6, store.
		for (int t = 0; t < NumAluTests; t++)
		begin
			if (isShift(testOps[t]))
				emit(encodeRegs(testOps[t], 3'd4, 3'd1, 3'd3));
			else
				emit(encodeRegs(testOps[t], 3'd4, 3'd2, 3'd1));  // Sub goes negative.
			emit(encodeImm(opLdi, 3'd6, 9'(ResultBase + t)));
			emit(encodeRegs(opSt, 3'd4, 3'd6, 3'd0));
		end
		emit(encodeImm(opLdi, 3'd6, 9'(LoadSrc)));    // Copy one word.
		emit(encodeRegs(opLd, 3'd5, 3'd6, 3'd0));
		emit(encodeImm(opLdi, 3'd6, 9'(CopyDst)));
		emit(encodeRegs(opSt, 3'd5, 3'd6, 3'd0));
		emit(encodeImm(opLdi, 3'd0, 9'(progLen + 3))); // Halt address.
		emit(encodeRegs(opJmp, 3'd0, 3'd0, 3'd0));
		emit(encodeRegs(opSt, 3'd4, 3'd2, 3'd0));      // Poison word.
		emit(encodeRegs(opHalt, 3'd0, 3'd0, 3'd0));
	endtask

	task automatic checkResults();
		logic [Bits-1:0] a;
		logic [Bits-1:0] b;
		for (int t = 0; t < NumAluTests; t++)
		begin
			a = isShift(testOps[t]) ? zeroExtend(ImmA) : zeroExtend(ImmB);
			b = isShift(testOps[t]) ? zeroExtend(ImmSh) : zeroExtend(ImmA);
			checkValue(testNames[t], expectedResult(testOps[t], a, b), mem[8'(ResultBase + t)]);
		end
		checkValue("load store copy", fillWord(LoadSrc), mem[CopyDst]);
		checkValue("poison skipped", fillWord(PoisonDst), mem[PoisonDst]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	// Random 0 to 3 cycle latency per access.
	always @(negedge CLK)
	begin
		if ((memRead || memWrite) && !memReady)
		begin
			if (waitLeft == 2'd0)
			begin
				memReady <= 1'b1;
				if (memRead)
					memRdData <= mem[memAddr[7:0]];
				else
					mem[memAddr[7:0]] <= memWrData;
			end
			else
				waitLeft <= waitLeft - 1'b1;
		end
		else
		begin
			memReady <= 1'b0;
			lcgState = lcgNext(lcgState);
			waitLeft <= lcgState[17:16];  // Delay for the next access.
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		loadProgram();
		@(posedge CLK);
		@(negedge CLK);
		checkValue("reset memRead", '0, Bits'(memRead));  // Quiet in reset.
		checkValue("reset memWrite", '0, Bits'(memWrite));
		checkValue("reset halted", '0, Bits'(halted));
		@(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		while (memRead !== 1'b1)
			@(negedge CLK);
		checkValue("first fetch address", '0, memAddr);
		while (halted !== 1'b1)
			@(negedge CLK);
		checkResults();
		// Halt is permanent and silent.
		repeat (20)
		begin
			@(negedge CLK);
			checkValue("halted held", 16'h0001, Bits'(halted));
			checkValue("strobes after halt", '0, Bits'({memRead, memWrite}));
		end
		$display("Done: no errors");
		$finish;
	end

	initial
	begin
		#(WatchdogTime);
		$display("Watchdog expired because the core never reached halt");
		$display("Done: errors found");
		$fatal(1);
	end

endmodule

`default_nettype wire
